// File: project.f
valu_types_pkg.sv
valu_op_pkg.sv
valu_ctrl.sv
valu_simd_mult.sv
valu_simd_add.sv
valu_sat_shift.sv
valu_mult_add.sv
valu_top.sv
tb_valu.sv

// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build tb_valu with Verilator and run it, log in $(LOG)"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_valu \
		-f project.f -o sim_valu
	-./obj_dir/sim_valu > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: tb_valu.sv
`timescale 1ns/1ns

module tb_valu;
  import valu_types_pkg::*;
  import valu_op_pkg::*;

  localparam int CLK_PERIOD  = 10;
  localparam int N_RAND      = 32;
  // ops issued by all tests together
  localparam int TOTAL_OPS   = 6 * N_RAND + 29;
  localparam int WATCHDOG_NS = (TOTAL_OPS * 20 + 100) * CLK_PERIOD;

  logic        clk;
  logic        arst_n;
  logic        enable;
  logic        in_valid;
  valu_opcode  opcode;
  valu_conf    conf;
  lane_word    a;
  lane_word    b;
  result_word  result;
  logic        result_valid;

  logic [31:0] lfsr = 32'hb1dd;
  logic [31:0] exp_q[$];
  int          issue_q[$];
  int          edge_cnt, errors, checked, max_depth, stall_edges;
  int          tests_ok, tests_bad, test_num, err_at_start;
  string       test_name;
  logic        stalls;

  valu_opcode  all_ops [7] = '{op_mul, op_mul_frac, op_mul_elem_sat, op_add, op_sub,
                               op_add_sat, op_sub_sat};
  valu_opcode  sat_ops [3] = '{op_add_sat, op_sub_sat, op_mul_elem_sat};

  valu_top i_dut (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ------------------------------
  // stimulus helpers
  // ------------------------------

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic next_bit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], next_bit()};
    end
    return v;
  endfunction

  function automatic logic [15:0] rand_word();
    logic [31:0] v;
    v = rand_bits(16);
    return v[15:0];
  endfunction

  // expected result computed element by element
  function automatic logic [31:0] model(valu_opcode op, valu_conf c, lane_word x, lane_word y);
    logic [31:0]        res;
    logic signed [63:0] ea, eb, v, hi, lo, lane_max;
    int                 ew;
    res      = '0;
    ew       = (c == conf_half) ? 8 : 16;
    hi       = (64'sd1 <<< (ew - 1)) - 1;
    lo       = -(64'sd1 <<< (ew - 1));
    lane_max = (64'sd1 <<< (2 * ew - 1)) - 1;
    for (int k = 0; k < ((c == conf_half) ? 2 : 1); k++) begin
      ea = (c == conf_half) ? $signed(x.half[k]) : x.full;
      eb = (c == conf_half) ? $signed(y.half[k]) : y.full;
      case (op)
        op_add, op_add_sat: v = ea + eb;
        op_sub, op_sub_sat: v = ea - eb;
        default:            v = ea * eb;
      endcase
      if (op == op_mul_frac) begin
        v = (2 * v > lane_max) ? lane_max : 2 * v;
      end else if (op == op_mul_elem_sat || op == op_add_sat || op == op_sub_sat) begin
        v = (v > hi) ? hi : ((v < lo) ? lo : v);
        // element goes to the upper half of its lane
        v = v <<< ew;
      end
      if (c == conf_half) begin
        res[16*k +: 16] = v[15:0];
      end else begin
        res = v[31:0];
      end
    end
    return res;
  endfunction

  // hold the op until an enabled edge takes it
  task automatic issue(valu_opcode op, valu_conf c, lane_word x, lane_word y);
    logic en;
    en       = 1'b0;
    opcode   = op;
    conf     = c;
    a        = x;
    b        = y;
    in_valid = 1'b1;
    while (!en) begin
      en     = stalls ? (rand_bits(2) != 0) : 1'b1;
      enable = en;
      @(negedge clk);
    end
    in_valid = 1'b0;
  endtask

  task automatic issue_random(valu_opcode op);
    issue(op, valu_conf'(rand_bits(1)), rand_word(), rand_word());
  endtask

  task automatic drain();
    enable   = 1'b1;
    in_valid = 1'b0;
    while (exp_q.size() != 0) @(negedge clk);
  endtask

  task automatic start_test(string name);
    test_num++;
    test_name    = name;
    err_at_start = errors;
  endtask

  task automatic close_test();
    drain();
    if (errors == err_at_start) begin
      tests_ok++;
      $display("test %0d %s: ok", test_num, test_name);
    end else begin
      tests_bad++;
      $display("test %0d %s: %0d errors", test_num, test_name, errors - err_at_start);
    end
  endtask

  // ------------------------------
  // checking
  // ------------------------------

  // results are consumed on the enabled edge that moves them on
  always @(posedge clk) begin
    if (arst_n && enable) begin
      if (result_valid) begin
        assert (exp_q.size() != 0) else begin
          $display("FAILED at %0t ns: result_valid high with nothing outstanding", $time);
          errors++;
        end
        if (exp_q.size() != 0) begin
          assert (result.full == exp_q[0]) else begin
            $display("FAILED at %0t ns: result %h, expected %h", $time, result, exp_q[0]);
            errors++;
          end
          assert (edge_cnt == issue_q[0] + NUM_STAGES) else begin
            $display("FAILED at %0t ns: latency %0d edges", $time, edge_cnt - issue_q[0]);
            errors++;
          end
          void'(exp_q.pop_front());
          void'(issue_q.pop_front());
          checked++;
        end
      end
      if (in_valid) begin
        exp_q.push_back(model(opcode, conf, a, b));
        issue_q.push_back(edge_cnt);
      end
      max_depth = (exp_q.size() > max_depth) ? exp_q.size() : max_depth;
      edge_cnt++;
    end else if (arst_n) begin
      stall_edges++;
    end
  end

  // a stalled edge leaves the outputs untouched
  assert property (@(posedge clk) disable iff (!arst_n)
    !enable |=> $stable(result.full) && $stable(result_valid))
  else begin
    $display("FAILED at %0t ns: outputs changed across a stalled edge", $time);
    errors++;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the run hung, outstanding results never arrived");
    $display("TESTBENCH FAILED");
    $finish;
  end

  // ------------------------------
  // tests
  // ------------------------------

  initial begin
    valu_conf c;
    lane_word max_w;
    lane_word min_w;
    clk = 1'b0;
    arst_n = 1'b0;
    enable = 1'b0;
    in_valid = 1'b0;
    opcode = op_mul;
    conf = conf_full;
    a = '0;
    b = '0;
    stalls = 1'b0;
    edge_cnt = 0;
    errors = 0;
    checked = 0;
    max_depth = 0;
    stall_edges = 0;
    tests_ok = 0;
    tests_bad = 0;
    test_num = 0;
    err_at_start = 0;
    repeat (2) @(posedge clk);
    assert (!result_valid) else begin
      $display("FAILED at %0t ns: result_valid high during reset", $time);
      errors++;
    end
    @(negedge clk);
    arst_n = 1'b1;
    enable = 1'b1;

    start_test("plain multiply");
    // upper and lower lanes differ in sign
    issue(op_mul, conf_half, 16'h807f, 16'h8081);
    issue(op_mul, conf_half, 16'h7f80, 16'hff80);
    repeat (N_RAND) issue_random(op_mul);
    close_test();

    start_test("fractional multiply");
    issue(op_mul_frac, conf_full, 16'h8000, 16'h8000);
    issue(op_mul_frac, conf_half, 16'h8080, 16'h8080);
    repeat (N_RAND) issue_random(op_mul_frac);
    close_test();

    start_test("add and subtract");
    issue(op_add, conf_half, 16'h7f7f, 16'h7f7f);
    issue(op_sub, conf_half, 16'h80ff, 16'h7f01);
    repeat (N_RAND) issue_random(rand_bits(1) ? op_sub : op_add);
    close_test();

    start_test("saturation");
    for (int i = 0; i < 2; i++) begin
      c     = valu_conf'(i);
      max_w = (c == conf_half) ? 16'h7f7f : 16'h7fff;
      min_w = (c == conf_half) ? 16'h8080 : 16'h8000;
      issue(op_add_sat, c, max_w, max_w);
      issue(op_add_sat, c, min_w, min_w);
      issue(op_sub_sat, c, min_w, max_w);
      issue(op_sub_sat, c, max_w, min_w);
      issue(op_mul_elem_sat, c, max_w, max_w);
      issue(op_mul_elem_sat, c, min_w, max_w);
      issue(op_mul_elem_sat, c, 16'h0003, 16'hfffb);
    end
    repeat (N_RAND) issue_random(sat_ops[rand_bits(2) % 3]);
    close_test();

    start_test("timing");
    issue(op_add, conf_full, 16'h0001, 16'h0002);
    assert (!result_valid) else begin
      $display("FAILED at %0t ns: result_valid high one edge early", $time);
      errors++;
    end
    @(negedge clk);
    assert (result_valid) else begin
      $display("FAILED at %0t ns: result_valid low two edges after issue", $time);
      errors++;
    end
    drain();
    max_depth = 0;
    repeat (8) issue_random(all_ops[rand_bits(3) % 7]);
    drain();
    assert (max_depth >= 2) else begin
      $display("back-to-back issues never had two operations in flight");
      errors++;
    end
    close_test();

    start_test("random stalls");
    stall_edges = 0;
    stalls      = 1'b1;
    repeat (2 * N_RAND) issue_random(all_ops[rand_bits(3) % 7]);
    stalls = 1'b0;
    drain();
    assert (stall_edges != 0) else begin
      $display("no stalled edge happened while traffic was running");
      errors++;
    end
    close_test();

    $display("tests: %0d ok, %0d with errors, %0d results checked, %0d errors",
             tests_ok, tests_bad, checked, errors);
    if (tests_bad == 0 && errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: valu_top.sv
`timescale 1ns/1ns

module valu_top (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       enable,
  input  logic                       in_valid,
  input  valu_op_pkg::valu_opcode    opcode,
  input  valu_op_pkg::valu_conf      conf,
  input  valu_types_pkg::lane_word   a,
  input  valu_types_pkg::lane_word   b,
  output valu_types_pkg::result_word result,
  output logic                       result_valid
);
  import valu_op_pkg::*;

  // decoded operation, registered inside the datapath
  mult_add_ctrl ctrl;

  valu_ctrl i_ctrl (
    .clk          (clk),
    .arst_n       (arst_n),
    .enable       (enable),
    .in_valid     (in_valid),
    .opcode       (opcode),
    .conf         (conf),
    .ctrl         (ctrl),
    .result_valid (result_valid)
  );

  valu_mult_add i_mult_add (
    .clk    (clk),
    .enable (enable),
    .ctrl   (ctrl),
    .a      (a),
    .b      (b),
    .result (result)
  );

endmodule

// File: valu_mult_add.sv
`timescale 1ns/1ns

module valu_mult_add (
  input  logic                       clk,
  input  logic                       enable,
  input  valu_op_pkg::mult_add_ctrl  ctrl,
  input  valu_types_pkg::lane_word   a,
  input  valu_types_pkg::lane_word   b,
  output valu_types_pkg::result_word result
);
  import valu_types_pkg::*;
  import valu_op_pkg::*;

  lane_word     a_pipe    [NUM_STAGES];
  lane_word     b_pipe    [NUM_STAGES];
  mult_add_ctrl ctrl_pipe [NUM_STAGES];

  lane_word     a_d;
  lane_word     b_d;
  mult_add_ctrl ctrl_d;

  result_word   a_ext;
  result_word   b_raw;
  result_word   b_ext;
  result_word   product;
  result_word   sum;
  result_word   shift_in;

  // widen an operand to the result format, one lane per element
  function automatic result_word sign_extend(lane_word x, valu_conf c);
    result_word rv;
    if (c == conf_half) begin
      for (int i = 0; i < NUM_LANES; i++) begin
        rv.lane[i] = {{HALF_WIDTH{x.half[i][HALF_WIDTH-1]}}, x.half[i]};
      end
    end else begin
      rv.full = {{WIDTH{x.full[WIDTH-1]}}, x.full};
    end
    return rv;
  endfunction

  // ------------------------------
  // input pipeline
  // ------------------------------

  // the whole pipeline holds while enable is low
  always_ff @(posedge clk) begin
    if (enable) begin
      a_pipe[0]    <= a;
      b_pipe[0]    <= b;
      ctrl_pipe[0] <= ctrl;
      for (int i = 1; i < NUM_STAGES; i++) begin
        a_pipe[i]    <= a_pipe[i-1];
        b_pipe[i]    <= b_pipe[i-1];
        ctrl_pipe[i] <= ctrl_pipe[i-1];
      end
    end
  end

  assign a_d    = a_pipe[NUM_STAGES-1];
  assign b_d    = b_pipe[NUM_STAGES-1];
  assign ctrl_d = ctrl_pipe[NUM_STAGES-1];

  // ------------------------------
  // operand preparation
  // ------------------------------

  assign a_ext = sign_extend(a_d, ctrl_d.conf);
  assign b_raw = sign_extend(b_d, ctrl_d.conf);

  // negation happens after extension, so the element minimum
  // negates without overflow
  always_comb begin
    b_ext = b_raw;
    if (ctrl_d.negate_b) begin
      if (ctrl_d.conf == conf_half) begin
        for (int i = 0; i < NUM_LANES; i++) begin
          b_ext.lane[i] = -b_raw.lane[i];
        end
      end else begin
        b_ext.full = -b_raw.full;
      end
    end
  end

  // ------------------------------
  // arithmetic
  // ------------------------------

  valu_simd_mult i_mult (
    .a       (a_d),
    .b       (b_d),
    .conf    (ctrl_d.conf),
    .product (product)
  );

  valu_simd_add i_add (
    .a_ext (a_ext),
    .b_ext (b_ext),
    .conf  (ctrl_d.conf),
    .sum   (sum)
  );

  assign shift_in = (ctrl_d.sel == sel_add) ? sum : product;

  valu_sat_shift i_sat (
    .x          (shift_in),
    .conf       (ctrl_d.conf),
    .fractional (ctrl_d.shift_fractional),
    .elem_sat   (ctrl_d.mult_shift),
    .y          (result)
  );

endmodule

// File: valu_sat_shift.sv
`timescale 1ns/1ns

module valu_sat_shift (
  input  valu_types_pkg::result_word x,
  input  valu_op_pkg::valu_conf      conf,
  input  logic                       fractional,
  input  logic                       elem_sat,
  output valu_types_pkg::result_word y
);
  import valu_types_pkg::*;
  import valu_op_pkg::*;

  result_word frac_y;
  result_word sat_y;

  // ------------------------------
  // fractional shift
  // ------------------------------

  // shift left by one; a lane whose top bits are 01 would overflow
  // and is replaced by its largest positive value
  always_comb begin
    if (conf == conf_half) begin
      for (int i = 0; i < NUM_LANES; i++) begin
        if (x.lane[i][WIDTH-1 -: 2] == 2'b01) begin
          frac_y.lane[i] = LANE_MAX;
        end else begin
          frac_y.lane[i] = {x.lane[i][WIDTH-2:0], 1'b0};
        end
      end
    end else begin
      if (x.full[RESULT_WIDTH-1 -: 2] == 2'b01) begin
        frac_y.full = WORD_MAX;
      end else begin
        frac_y.full = {x.full[RESULT_WIDTH-2:0], 1'b0};
      end
    end
  end

  // ------------------------------
  // element saturation
  // ------------------------------

  // clamp each lane to the element range, then move the element to
  // the upper half of its lane
  always_comb begin
    if (conf == conf_half) begin
      for (int i = 0; i < NUM_LANES; i++) begin
        if ($signed(x.lane[i]) > ELEM_HALF_MAX) begin
          sat_y.lane[i] = {ELEM_HALF_MAX, {HALF_WIDTH{1'b0}}};
        end else if ($signed(x.lane[i]) < ELEM_HALF_MIN) begin
          sat_y.lane[i] = {ELEM_HALF_MIN, {HALF_WIDTH{1'b0}}};
        end else begin
          sat_y.lane[i] = {x.lane[i][HALF_WIDTH-1:0], {HALF_WIDTH{1'b0}}};
        end
      end
    end else begin
      if (x.full > ELEM_FULL_MAX) begin
        sat_y.full = {ELEM_FULL_MAX, {WIDTH{1'b0}}};
      end else if (x.full < ELEM_FULL_MIN) begin
        sat_y.full = {ELEM_FULL_MIN, {WIDTH{1'b0}}};
      end else begin
        sat_y.full = {x.full[WIDTH-1:0], {WIDTH{1'b0}}};
      end
    end
  end

  // the decoder never sets both flags
  always_comb begin
    if (elem_sat) begin
      y = sat_y;
    end else if (fractional) begin
      y = frac_y;
    end else begin
      y = x;
    end
  end

endmodule

// File: valu_simd_add.sv
`timescale 1ns/1ns

module valu_simd_add (
  input  valu_types_pkg::result_word a_ext,
  input  valu_types_pkg::result_word b_ext,
  input  valu_op_pkg::valu_conf      conf,
  output valu_types_pkg::result_word sum
);
  import valu_types_pkg::*;
  import valu_op_pkg::*;

  // operands arrive already sign extended per lane, so the
  // sums are exact and only the carry chain depends on conf
  always_comb begin
    if (conf == conf_half) begin
      // lanes are split, no carry crosses bit 16
      for (int i = 0; i < NUM_LANES; i++) begin
        sum.lane[i] = a_ext.lane[i] + b_ext.lane[i];
      end
    end else begin
      sum.full = a_ext.full + b_ext.full;
    end
  end

endmodule

// File: valu_simd_mult.sv
`timescale 1ns/1ns

module valu_simd_mult (
  input  valu_types_pkg::lane_word   a,
  input  valu_types_pkg::lane_word   b,
  input  valu_op_pkg::valu_conf      conf,
  output valu_types_pkg::result_word product
);
  import valu_types_pkg::*;
  import valu_op_pkg::*;

  // one signed 16x16 product or two signed 8x8 products
  always_comb begin
    if (conf == conf_half) begin
      // each lane takes its own pair of elements
      for (int i = 0; i < NUM_LANES; i++) begin
        product.lane[i] = $signed(a.half[i]) * $signed(b.half[i]);
      end
    end else begin
      product.full = $signed(a.full) * $signed(b.full);
    end
  end

endmodule

// File: valu_ctrl.sv
`timescale 1ns/1ns

module valu_ctrl (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      enable,
  input  logic                      in_valid,
  input  valu_op_pkg::valu_opcode   opcode,
  input  valu_op_pkg::valu_conf     conf,
  output valu_op_pkg::mult_add_ctrl ctrl,
  output logic                      result_valid
);
  import valu_op_pkg::*;

  logic [NUM_STAGES-1:0] valid_pipe;

  // ------------------------------
  // opcode decode
  // ------------------------------

  always_comb begin
    ctrl.conf             = conf;
    ctrl.negate_b         = 1'b0;
    ctrl.mult_shift       = 1'b0;
    ctrl.shift_fractional = 1'b0;
    ctrl.sel              = sel_mul;

    case (opcode)
      op_mul_frac: ctrl.shift_fractional = 1'b1;
      op_mul_elem_sat: ctrl.mult_shift = 1'b1;
      op_add: ctrl.sel = sel_add;
      op_sub: begin
        ctrl.sel      = sel_add;
        ctrl.negate_b = 1'b1;
      end
      op_add_sat: begin
        ctrl.sel        = sel_add;
        ctrl.mult_shift = 1'b1;
      end
      op_sub_sat: begin
        ctrl.sel        = sel_add;
        ctrl.negate_b   = 1'b1;
        ctrl.mult_shift = 1'b1;
      end
      // op_mul and the unused code fall back to a plain multiply
      default: ctrl.sel = sel_mul;
    endcase
  end

  // ------------------------------
  // valid tracking
  // ------------------------------

  // same depth as the data pipeline, frozen while stalled
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_pipe <= '0;
    end else if (enable) begin
      valid_pipe <= {valid_pipe[NUM_STAGES-2:0], in_valid};
    end
  end

  assign result_valid = valid_pipe[NUM_STAGES-1];

endmodule

// File: valu_op_pkg.sv
package valu_op_pkg;

  // number of input register stages in front of the datapath
  localparam int NUM_STAGES = 2;

  // ------------------------------
  // operation encodings
  // ------------------------------

  // vector configuration of an operand word
  typedef enum logic {
    conf_full = 1'b0,
    conf_half = 1'b1
  } valu_conf;

  // which arithmetic unit feeds the shifter
  typedef enum logic {
    sel_mul = 1'b0,
    sel_add = 1'b1
  } result_sel;

  typedef enum logic [2:0] {
    op_mul          = 3'd0,
    op_mul_frac     = 3'd1,
    op_mul_elem_sat = 3'd2,
    op_add          = 3'd3,
    op_sub          = 3'd4,
    op_add_sat      = 3'd5,
    op_sub_sat      = 3'd6
  } valu_opcode;

  // ------------------------------
  // decoded control
  // ------------------------------

  // travels down the input pipeline next to the operands
  typedef struct packed {
    valu_conf  conf;
    logic      negate_b;
    logic      mult_shift;        // element saturation
    logic      shift_fractional;  // saturating shift left by one
    result_sel sel;
  } mult_add_ctrl;

endpackage

// File: valu_types_pkg.sv
package valu_types_pkg;

  // ------------------------------
  // widths
  // ------------------------------

  localparam int WIDTH        = 16;
  localparam int HALF_WIDTH   = WIDTH / 2;
  localparam int RESULT_WIDTH = 2 * WIDTH;
  localparam int NUM_LANES    = 2;

  // ------------------------------
  // saturation limits
  // ------------------------------

  // element range in full mode, one 16 bit element per word
  localparam logic signed [WIDTH-1:0] ELEM_FULL_MAX = {1'b0, {WIDTH-1{1'b1}}};
  localparam logic signed [WIDTH-1:0] ELEM_FULL_MIN = {1'b1, {WIDTH-1{1'b0}}};

  // element range in half mode
  localparam logic signed [HALF_WIDTH-1:0] ELEM_HALF_MAX = {1'b0, {HALF_WIDTH-1{1'b1}}};
  localparam logic signed [HALF_WIDTH-1:0] ELEM_HALF_MIN = {1'b1, {HALF_WIDTH-1{1'b0}}};

  // largest positive value of a 16 bit result lane and of the whole result
  localparam logic signed [WIDTH-1:0]        LANE_MAX = {1'b0, {WIDTH-1{1'b1}}};
  localparam logic signed [RESULT_WIDTH-1:0] WORD_MAX = {1'b0, {RESULT_WIDTH-1{1'b1}}};

  // ------------------------------
  // data words
  // ------------------------------

  // operand, either one signed element or two signed halves
  // half[1] is bits 15..8
  typedef union packed {
    logic signed [WIDTH-1:0]                     full;
    logic        [NUM_LANES-1:0][HALF_WIDTH-1:0] half;
  } lane_word;

  // result, either one signed 32 bit value or two 16 bit lanes
  typedef union packed {
    logic signed [RESULT_WIDTH-1:0]         full;
    logic        [NUM_LANES-1:0][WIDTH-1:0] lane;
  } result_word;

endpackage
